// ==== burst_reader.sv ====
`default_nettype none

module burst_reader (
	input  wire         clock,
	input  wire         reset,
	input  wire         read_start,
	input  wire  [31:0] read_addr,
	input  wire         read_burst,
	output logic        read_busy,
	output logic [31:0] araddr,
	output logic        arvalid,
	input  wire         arready,
	output logic [1:0]  arburst,
	output logic [3:0]  arlen,
	input  wire  [31:0] rdata,
	input  wire  [1:0]  rresp,
	input  wire         rlast,
	input  wire         rvalid,
	output logic        rready,
	output logic [31:0] beat_data,
	output logic        beat_valid,
	output logic        beat_last
);
	import fetch_pkg::*;
	import bus_pkg::*;

	assign rready = 1'b1; // fetch always sinks returned data

	assign beat_valid = rvalid && rready && read_busy;
	assign beat_data  = rdata;
	assign beat_last  = rlast;

	always_ff @(posedge clock) begin
		if (reset) begin
			arvalid   <= 1'b0;
			read_busy <= 1'b0;
		end else begin
			if (read_start) begin
				arvalid <= 1'b1;
			end else if (arvalid && arready) begin
				arvalid <= 1'b0;
			end

			if (read_start) begin
				read_busy <= 1'b1;
			end else if (beat_valid && beat_last) begin
				read_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (read_start) begin
			if (read_burst) begin
				araddr  <= block_base(read_addr); // refill always starts at word 0
				arburst <= burst_incr;
				arlen   <= len_block;
			end else begin
				araddr  <= read_addr;
				arburst <= burst_fixed;
				arlen   <= len_single;
			end
		end
	end

	a_addr_stable: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
		else $error("burst_reader: request changed before arready");

	a_resp_okay: assert property (@(posedge clock) disable iff (reset)
		rvalid && rready |-> rresp == resp_okay)
		else $error("burst_reader: rresp %0h on a read beat", rresp);

	a_start_idle: assert property (@(posedge clock) disable iff (reset)
		read_start |-> !read_busy)
		else $error("burst_reader: read_start while a read is outstanding");

endmodule

`default_nettype wire

// ==== bus_pkg.sv ====
`default_nettype none

package bus_pkg;

	localparam logic [1:0] burst_fixed = 2'b00;
	localparam logic [1:0] burst_incr  = 2'b01; // used for block refills

	// arlen is beats minus one
	localparam logic [3:0] len_single = 4'd0;
	localparam logic [3:0] len_block  = 4'd7;

	localparam logic [1:0] resp_okay = 2'b00;

endpackage

`default_nettype wire

// ==== fetch_control.sv ====
`default_nettype none

module fetch_control #(
	parameter int num_sets = 16
) (
	input  wire         clock,
	input  wire         reset,
	output logic [31:0] lookup_addr,
	output logic        lookup_req,
	input  wire         lookup_done,
	input  wire         hit,
	input  wire  [31:0] hit_data,
	output logic        read_start,
	output logic [31:0] read_addr,
	output logic        read_burst,
	input  wire         read_busy,
	input  wire  [31:0] beat_data,
	input  wire         beat_valid,
	input  wire         beat_last,
	input  wire         jump_wrong,
	input  wire  [31:0] jump_addr,
	input  wire  [31:0] dnpc,
	output logic [31:0] pc,
	output logic [31:0] inst,
	output logic        idu_valid,
	input  wire         idu_ready
);
	import fetch_pkg::*;

	localparam int index_bits = $clog2(num_sets);
	localparam int word_bits  = $clog2(block_words);
	localparam int tag_bits   = 32 - offset_bits - index_bits;

	typedef enum logic [1:0] {
		s_lookup,
		s_wait_beat,
		s_deliver,
		s_flush
	} state_t;

	state_t               state;
	logic [31:0]          req_addr;
	logic                 bypass; // outstanding read is a single beat
	logic [word_bits-1:0] beat_count;
	logic                 start_bypass;
	logic                 beat_match;

	logic                  refill_ok;
	logic [index_bits-1:0] refill_set;
	logic [tag_bits-1:0]   refill_tag;

	assign lookup_addr  = pc;
	assign lookup_req   = (state == s_lookup) && in_sdram(pc) && !read_busy && !lookup_done
		&& !jump_wrong;
	assign start_bypass = (state == s_lookup) && !in_sdram(pc) && !read_busy;
	// a miss still refills even if a redirect arrives in the same cycle
	assign read_start   = start_bypass || ((state == s_lookup) && lookup_done && !hit);
	assign read_burst   = in_sdram(pc);
	assign read_addr    = (state == s_lookup) ? pc : req_addr; // held while a read drains
	assign beat_match   = beat_valid && (bypass || (beat_count == pc[offset_bits-1:2]));
	assign idu_valid    = (state == s_deliver);

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= s_lookup;
			pc        <= reset_vector;
			refill_ok <= 1'b0;
		end else begin
			if (jump_wrong) begin
				pc <= jump_addr;
			end else if (idu_valid && idu_ready) begin
				pc <= dnpc;
			end

			if (jump_wrong) begin
				state <= s_flush; // whatever is in flight is dropped
			end else begin
				case (state)
					s_lookup: begin
						if (lookup_done) begin
							state <= hit ? s_deliver : s_wait_beat;
						end else if (start_bypass) begin
							state <= s_wait_beat;
						end
					end
					s_wait_beat: if (beat_match) state <= s_deliver;
					s_deliver:   if (idu_ready) state <= s_lookup;
					s_flush:     if (!read_busy) state <= s_lookup; // let a burst finish into the cache
					default:     state <= s_lookup;
				endcase
			end

			if (read_start) begin
				refill_ok <= 1'b0;
			end else if (beat_valid && beat_last && !bypass) begin
				refill_ok <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (read_start) begin
			req_addr   <= pc;
			bypass     <= !in_sdram(pc);
			beat_count <= '0;
			refill_set <= pc[offset_bits +: index_bits];
			refill_tag <= pc[31 -: tag_bits];
		end else if (beat_valid) begin
			beat_count <= beat_count + 1'b1;
		end

		if ((state == s_lookup) && lookup_done && hit) begin
			inst <= hit_data;
		end else if ((state == s_wait_beat) && beat_match) begin
			inst <= beat_data;
		end
	end

	a_hold: assert property (@(posedge clock) disable iff (reset)
		idu_valid && !idu_ready && !jump_wrong |=> $stable(inst) && $stable(pc))
		else $error("fetch_control: inst or pc moved under back-pressure");

	// the block refilled last must be found by the next lookup into it
	a_refill_hits: assert property (@(posedge clock) disable iff (reset)
		lookup_done && refill_ok && (pc[offset_bits +: index_bits] == refill_set)
		&& (pc[31 -: tag_bits] == refill_tag) |-> hit)
		else $error("fetch_control: miss on a freshly refilled block at %h", pc);

endmodule

`default_nettype wire

// ==== fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	localparam logic [31:0] reset_vector = 32'h3000_0000; // uncached boot region
	localparam logic [31:0] sdram_base   = 32'ha000_0000;
	localparam logic [31:0] sdram_limit  = 32'ha200_0000; // first address past the window

	localparam int block_words = 8;
	localparam int offset_bits = 5; // byte offset inside one block

	// only the sdram window is cacheable, everything else is fetched word by word
	function automatic logic in_sdram(input logic [31:0] addr);
		return (addr >= sdram_base) && (addr < sdram_limit);
	endfunction

	function automatic logic [31:0] block_base(input logic [31:0] addr);
		return {addr[31:offset_bits], {offset_bits{1'b0}}};
	endfunction

endpackage

`default_nettype wire

// ==== fetch_top.sv ====
`default_nettype none

module fetch_top #(
	parameter int num_sets = 16
) (
	input  wire         clock,
	input  wire         reset,
	output logic [31:0] araddr,
	output logic        arvalid,
	input  wire         arready,
	output logic [1:0]  arburst,
	output logic [3:0]  arlen,
	input  wire  [31:0] rdata,
	input  wire  [1:0]  rresp,
	input  wire         rlast,
	input  wire         rvalid,
	output logic        rready,
	input  wire         jump_wrong,
	input  wire  [31:0] jump_addr,
	input  wire  [31:0] dnpc,
	output logic [31:0] pc,
	output logic [31:0] inst,
	output logic        idu_valid,
	input  wire         idu_ready
);

	logic [31:0] lookup_addr;
	logic        lookup_req;
	logic        lookup_done;
	logic        hit;
	logic [31:0] hit_data;
	logic        read_start;
	logic [31:0] read_addr;
	logic        read_burst;
	logic        read_busy;
	logic [31:0] beat_data;
	logic        beat_valid;
	logic        beat_last;

	icache #(
		.num_sets(num_sets)
	) u_icache (
		.clock(clock),
		.reset(reset),
		.lookup_addr(lookup_addr),
		.lookup_req(lookup_req),
		.lookup_done(lookup_done),
		.hit(hit),
		.hit_data(hit_data),
		.fill_addr(read_addr), // latched by the cache on a miss
		.beat_data(beat_data),
		.beat_valid(beat_valid),
		.beat_last(beat_last)
	);

	burst_reader u_burst_reader (
		.clock(clock),
		.reset(reset),
		.read_start(read_start),
		.read_addr(read_addr),
		.read_burst(read_burst),
		.read_busy(read_busy),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.arburst(arburst),
		.arlen(arlen),
		.rdata(rdata),
		.rresp(rresp),
		.rlast(rlast),
		.rvalid(rvalid),
		.rready(rready),
		.beat_data(beat_data),
		.beat_valid(beat_valid),
		.beat_last(beat_last)
	);

	fetch_control #(
		.num_sets(num_sets)
	) u_fetch_control (
		.clock(clock),
		.reset(reset),
		.lookup_addr(lookup_addr),
		.lookup_req(lookup_req),
		.lookup_done(lookup_done),
		.hit(hit),
		.hit_data(hit_data),
		.read_start(read_start),
		.read_addr(read_addr),
		.read_burst(read_burst),
		.read_busy(read_busy),
		.beat_data(beat_data),
		.beat_valid(beat_valid),
		.beat_last(beat_last),
		.jump_wrong(jump_wrong),
		.jump_addr(jump_addr),
		.dnpc(dnpc),
		.pc(pc),
		.inst(inst),
		.idu_valid(idu_valid),
		.idu_ready(idu_ready)
	);

endmodule

`default_nettype wire

// ==== filelist.f ====
fetch_pkg.sv
bus_pkg.sv
icache.sv
burst_reader.sv
fetch_control.sv
fetch_top.sv
tb_memory.sv
tb_fetch.sv

// ==== icache.sv ====
`default_nettype none

module icache #(
	parameter int num_sets = 16
) (
	input  wire         clock,
	input  wire         reset,
	input  wire  [31:0] lookup_addr,
	input  wire         lookup_req,
	output logic        lookup_done,
	output logic        hit,
	output logic [31:0] hit_data,
	input  wire  [31:0] fill_addr,
	input  wire  [31:0] beat_data,
	input  wire         beat_valid,
	input  wire         beat_last
);
	import fetch_pkg::*;

	localparam int index_bits = $clog2(num_sets);
	localparam int word_bits  = $clog2(block_words);
	localparam int tag_bits   = 32 - offset_bits - index_bits;

	logic [31:0]         data_mem [num_sets * block_words];
	logic [tag_bits-1:0] tag_mem  [num_sets];
	logic [num_sets-1:0] valid_bits;

	logic [index_bits-1:0] look_index;
	logic [tag_bits-1:0]   look_tag;
	logic                  miss;

	logic                  fill_open;
	logic [index_bits-1:0] fill_index;
	logic [word_bits-1:0]  fill_word;

	assign hit  = lookup_done && valid_bits[look_index] && (tag_mem[look_index] == look_tag);
	assign miss = lookup_done && !hit; // same cycle in which the refill is requested

	always_ff @(posedge clock) begin
		if (reset) begin
			lookup_done <= 1'b0;
			fill_open   <= 1'b0;
			valid_bits  <= '0;
		end else begin
			lookup_done <= lookup_req;
			if (miss) begin
				fill_open <= 1'b1;
				valid_bits[fill_addr[offset_bits +: index_bits]] <= 1'b0; // block is overwritten now
			end else if (beat_valid && fill_open && beat_last) begin
				fill_open              <= 1'b0;
				valid_bits[fill_index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (lookup_req) begin
			look_index <= lookup_addr[offset_bits +: index_bits];
			look_tag   <= lookup_addr[31 -: tag_bits];
			hit_data   <= data_mem[{lookup_addr[offset_bits +: index_bits],
				lookup_addr[offset_bits-1:2]}];
		end
		if (miss) begin
			fill_index <= fill_addr[offset_bits +: index_bits];
			fill_word  <= '0; // the burst starts at the block base
			tag_mem[fill_addr[offset_bits +: index_bits]] <= fill_addr[31 -: tag_bits];
		end else if (beat_valid && fill_open) begin
			data_mem[{fill_index, fill_word}] <= beat_data;
			fill_word <= fill_word + 1'b1;
		end
	end

	// bypass beats come back with a non-cacheable read address and are ignored here
	a_beat_in_fill: assert property (@(posedge clock) disable iff (reset)
		beat_valid |-> fill_open || !in_sdram(fill_addr))
		else $error("icache: refill beat without an open fill");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the fetch stage testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_fetch -f filelist.f -Mdir obj_dir -o sim_fetch
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_fetch)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Simulation PASSED$"; then
	exit 0
fi
exit 1

// ==== tb_fetch.sv ====
`default_nettype none

module tb_fetch;
	timeunit 1ns;
	timeprecision 100ps;
	import bus_pkg::*;

	localparam int          sets       = 16;
	localparam int          set_bits   = $clog2(sets);
	localparam logic [31:0] boot_pc    = 32'h3000_0000;
	localparam logic [31:0] xor_key    = 32'h5a5a_a5a5;
	localparam int          max_cycles = 4000; // worst-case stalls need about 1500 cycles

	logic        clock;
	logic        reset;
	logic [31:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [1:0]  arburst;
	logic [3:0]  arlen;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rlast;
	logic        rvalid;
	logic        rready;
	logic        jump_wrong;
	logic [31:0] jump_addr;
	logic [31:0] dnpc;
	logic [31:0] pc;
	logic [31:0] inst;
	logic        idu_valid;
	logic        idu_ready;

	integer      seed;
	int          errors;
	int          errors_before;
	int          tests;
	int          accepted;
	int          cycles;
	logic [31:0] expect_pc; // pc that the next acceptance must carry
	logic [31:0] given_pc;
	logic [31:0] jump_target;
	logic        accept_pending;
	logic        jump_pending;
	logic [31:0] loop_start;
	logic [31:0] loop_end;

	logic [31:0]         last_pc;
	logic                req_cached;
	logic [31:0]         req_block;
	logic [3:0]          beats;
	logic [31:0]         resident [sets];
	logic [sets-1:0]     resident_ok;
	logic [set_bits-1:0] last_set;
	logic                cached_again;

	fetch_top #(
		.num_sets(sets)
	) u_fetch_top (.*);

	tb_memory #(
		.xor_key(xor_key)
	) u_memory (.*);

	function automatic logic cacheable(input logic [31:0] addr);
		return (addr >= 32'ha000_0000) && (addr < 32'ha200_0000);
	endfunction

	function automatic logic [31:0] align_block(input logic [31:0] addr);
		return addr & ~32'h1f;
	endfunction

	function automatic logic [31:0] request_addr(input logic [31:0] addr);
		return cacheable(addr) ? align_block(addr) : addr;
	endfunction

	function automatic logic [5:0] request_shape(input logic [31:0] addr);
		return cacheable(addr) ? {burst_incr, len_block} : {burst_fixed, len_single};
	endfunction

	// straight-line code, except that loop_end branches back to loop_start
	function automatic logic [31:0] program_next(input logic [31:0] addr);
		if ((loop_end != 32'h0) && (addr == loop_end)) begin
			return loop_start;
		end
		return addr + 32'd4;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("MISMATCH %s: got %h expected %h", name, got, want);
		errors++;
	endtask

	task automatic flag_error(input string what);
		$display("error at cycle %0d: %s", cycles, what);
		errors++;
	endtask

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	initial begin
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: the tests did not finish within %0d cycles", max_cycles);
		$display("Simulation FAILED");
		$finish;
	end

	assign last_set     = last_pc[5 +: set_bits];
	assign cached_again = cacheable(last_pc) && resident_ok[last_set]
		&& (resident[last_set] == align_block(last_pc));

	// reference model of which blocks have been fully refilled
	always @(posedge clock) begin
		last_pc <= pc;
		if (reset) begin
			beats       <= 4'd0;
			resident_ok <= '0;
		end else begin
			if (arvalid && arready) begin
				req_cached <= cacheable(araddr);
				req_block  <= align_block(araddr);
			end
			if (rvalid && rready) begin
				beats <= rlast ? 4'd0 : beats + 4'd1;
			end
			if (rvalid && rready && rlast && req_cached) begin
				resident[req_block[5 +: set_bits]]    <= req_block;
				resident_ok[req_block[5 +: set_bits]] <= 1'b1; // an older block of the set is gone
			end
		end
	end

	a_reset_idle: assert property (@(posedge clock) reset |=> !idu_valid && !arvalid)
		else flag_error("idu_valid or arvalid was high right after reset");

	a_pc: assert property (@(posedge clock) disable iff (reset)
		idu_valid && idu_ready |-> pc == expect_pc)
		else report_mismatch("pc", $sampled(pc), $sampled(expect_pc));

	a_inst: assert property (@(posedge clock) disable iff (reset)
		idu_valid && idu_ready |-> inst == (pc ^ xor_key))
		else report_mismatch("inst", $sampled(inst), $sampled(pc) ^ xor_key);

	a_req_addr: assert property (@(posedge clock) disable iff (reset)
		$rose(arvalid) |-> araddr == request_addr(last_pc))
		else report_mismatch("araddr", $sampled(araddr), request_addr($sampled(last_pc)));

	a_req_shape: assert property (@(posedge clock) disable iff (reset)
		$rose(arvalid) |-> {arburst, arlen} == request_shape(last_pc))
		else report_mismatch("{arburst,arlen}", {26'd0, $sampled(arburst), $sampled(arlen)},
			{26'd0, request_shape($sampled(last_pc))});

	a_beats: assert property (@(posedge clock) disable iff (reset)
		rvalid && rready && rlast |-> beats == (req_cached ? 4'd7 : 4'd0))
		else report_mismatch("beat index at rlast", {28'd0, $sampled(beats)},
			req_cached ? 32'd7 : 32'd0);

	a_rready: assert property (@(posedge clock) disable iff (reset)
		rvalid |-> rready)
		else report_mismatch("rready", {31'd0, $sampled(rready)}, 32'd1);

	a_no_refetch: assert property (@(posedge clock) disable iff (reset)
		$rose(arvalid) |-> !cached_again)
		else flag_error("read request for a block that is already in the cache");

	a_hold: assert property (@(posedge clock) disable iff (reset)
		idu_valid && !idu_ready && !jump_wrong |=> idu_valid && $stable(pc) && $stable(inst))
		else flag_error("idu_valid, pc or inst changed while idu_ready was low");

	// drives one decode cycle with its inputs changing on the falling edge
	task automatic drive_cycle(input logic do_jump, input logic [31:0] target);
		@(negedge clock);
		if (accept_pending) begin
			expect_pc      = given_pc;
			accepted       = accepted + 1;
			accept_pending = 1'b0;
		end
		if (jump_pending) begin
			expect_pc    = jump_target;
			jump_pending = 1'b0;
		end
		jump_wrong = do_jump;
		jump_addr  = target;
		if (do_jump) begin
			idu_ready    = 1'b0; // an instruction on this edge would be flushed anyway
			jump_target  = target;
			jump_pending = 1'b1;
		end else begin
			idu_ready = ($random(seed) & 32'd3) != 0; // ready about three cycles in four
			if (idu_valid && idu_ready) begin
				given_pc       = program_next(expect_pc);
				dnpc           = given_pc;
				accept_pending = 1'b1;
			end
		end
	endtask

	task automatic run_accepts(input int count);
		int goal;
		goal = accepted + count;
		while (accepted < goal) drive_cycle(1'b0, 32'h0);
	endtask

	task automatic redirect(input logic [31:0] target);
		drive_cycle(1'b1, target);
	endtask

	task automatic redirect_mid_burst(input logic [31:0] first, input logic [31:0] second);
		redirect(first);
		while (!arvalid) drive_cycle(1'b0, 32'h0);
		repeat (3) drive_cycle(1'b0, 32'h0);
		redirect(second);
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %-18s %s, %0d accepted so far", name,
			(errors == errors_before) ? "ok" : "with errors", accepted);
		errors_before = errors;
	endtask

	initial begin
		seed           = 32'h7ebf_cba9;
		reset          = 1'b1;
		idu_ready      = 1'b0;
		dnpc           = 32'h0;
		jump_wrong     = 1'b0;
		jump_addr      = 32'h0;
		errors         = 0;
		errors_before  = 0;
		tests          = 0;
		accepted       = 0;
		expect_pc      = boot_pc;
		accept_pending = 1'b0;
		jump_pending   = 1'b0;
		loop_start     = 32'h0;
		loop_end       = 32'h0;
		repeat (4) @(negedge clock);
		reset = 1'b0;

		run_accepts(6);
		end_test("boot_uncached");

		redirect(32'ha000_0000);
		run_accepts(20);
		end_test("sdram_straight");

		loop_start = 32'ha000_0040;
		loop_end   = 32'ha000_005c;
		redirect(32'ha000_0048);
		run_accepts(30);
		end_test("block_loop");

		loop_start = 32'ha000_0100;
		loop_end   = 32'ha000_013c; // two blocks in neighbouring sets
		redirect(32'ha000_0100);
		run_accepts(40);
		end_test("two_block_loop");

		// these blocks all map to set 0 and evict each other
		loop_end = 32'h0;
		redirect(32'ha000_0208);
		run_accepts(4);
		redirect(32'ha000_0408);
		run_accepts(4);
		redirect(32'ha000_020c);
		run_accepts(4);
		end_test("set_conflict");

		redirect_mid_burst(32'ha000_0814, 32'ha000_0a08);
		run_accepts(6);
		redirect_mid_burst(32'ha000_0c00, 32'h3000_0040);
		run_accepts(4);
		end_test("redirect_in_burst");

		$display("%0d tests, %0d instructions accepted, %0d errors", tests, accepted, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_memory.sv ====
`default_nettype none

module tb_memory #(
	parameter logic [31:0] xor_key = 32'h5a5a_a5a5
) (
	input  wire         clock,
	input  wire         reset,
	input  wire  [31:0] araddr,
	input  wire         arvalid,
	output logic        arready,
	input  wire  [1:0]  arburst,
	input  wire  [3:0]  arlen,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rlast,
	output logic        rvalid,
	input  wire         rready
);
	timeunit 1ns;
	timeprecision 100ps;
	import bus_pkg::*;

	integer      seed;
	integer      wait_cycles;
	integer      last_beat;
	integer      beat;
	logic [31:0] base;
	logic        stepping; // incrementing burst, otherwise every beat reads the same word

	initial begin
		seed    = 32'h7ebf_cba9;
		arready = 1'b0;
		rvalid  = 1'b0;
		rlast   = 1'b0;
		rdata   = 32'h0;
		rresp   = resp_okay;
		forever begin
			@(negedge clock);
			if (!reset && arvalid) begin
				wait_cycles = $unsigned($random(seed)) % 4; // arready comes 0 to 3 cycles late
				repeat (wait_cycles) @(negedge clock);
				base      = araddr;
				last_beat = {28'd0, arlen};
				stepping  = (arburst == burst_incr);
				arready   = 1'b1;
				@(negedge clock);
				arready = 1'b0;
				for (beat = 0; beat <= last_beat; beat = beat + 1) begin
					wait_cycles = $unsigned($random(seed)) % 3;
					if (wait_cycles != 0) begin
						rvalid = 1'b0;
						rlast  = 1'b0;
						repeat (wait_cycles) @(negedge clock);
					end
					rdata  = (stepping ? base + 4 * beat : base) ^ xor_key;
					rlast  = (beat == last_beat);
					rvalid = 1'b1;
					@(negedge clock);
					while (!rready) @(negedge clock);
				end
				rvalid = 1'b0;
				rlast  = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire
